// File: source/noc_defs.svh
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Sample and flit payload width
`define NOC_DW 32

// Per-node accumulator width
`define SUM_DW 64

// Flit address field
`define ADDR_W 4

// Chain length, also the id of the end node
`define NUM_NODES 4

// Node 1 only packs flits, routers start here
`define FIRST_ROUTED_ID 2

`endif

// File: source/noc_pkg.sv
`include "noc_defs.svh"

package noc_pkg;

    // Raw sample as it enters the chain
    typedef logic [`NOC_DW-1:0] sample_t;

    // Running sum kept by each processor
    typedef logic [`SUM_DW-1:0] sum_t;

    typedef logic [`ADDR_W-1:0] node_id_t;

    // Link word, address in the upper bits
    typedef struct packed {
        node_id_t addr;
        sample_t  payload;
    } flit_t;

    // Ingress item before it is turned into a flit
    typedef struct packed {
        node_id_t dest;
        sample_t  sample;
    } addr_sample_t;

endpackage

// File: source/stream_slice.sv
`timescale 1ns/100ps

module stream_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    payload_t skid_payload;
    logic     skid_valid;
    logic     skid_next;
    logic     in_xfer;
    logic     out_advance;

    assign in_xfer     = in_valid && in_ready;
    // Output register can take a new word this cycle
    assign out_advance = !out_valid || out_ready;

    // Skid entry drains whenever the output moves
    assign skid_next = out_advance ? 1'b0 : (skid_valid || in_xfer);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (out_advance) begin
                out_valid <= skid_valid || in_xfer;
            end
            skid_valid <= skid_next;
            in_ready   <= !skid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (out_advance) begin
            if (skid_valid) begin
                out_payload <= skid_payload;
            end else if (in_xfer) begin
                out_payload <= in_payload;
            end
        end else if (in_xfer) begin
            // Output stalled, park the word
            skid_payload <= in_payload;
        end
    end

endmodule

// File: source/flit_packetizer.sv
`timescale 1ns/100ps
`include "noc_defs.svh"

module flit_packetizer (
    input  logic                 in_valid,
    output logic                 in_ready,
    input  noc_pkg::addr_sample_t in_item,
    output logic                 flit_valid,
    input  logic                 flit_ready,
    output noc_pkg::flit_t       flit
);

    // Header field from the destination
    assign flit.addr    = in_item.dest[`ADDR_W-1:0];

    // Sample rides unchanged in the payload
    assign flit.payload = in_item.sample[`NOC_DW-1:0];

    // No storage here, handshake passes straight through
    assign flit_valid = in_valid;
    assign in_ready   = flit_ready;

endmodule

// File: source/node_router.sv
`timescale 1ns/100ps
`include "noc_defs.svh"

module node_router #(
    parameter int NODE_ID = `FIRST_ROUTED_ID
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              up_valid,
    output logic              up_ready,
    input  noc_pkg::flit_t    up_flit,
    input  logic              local_valid,
    output logic              local_ready,
    input  noc_pkg::flit_t    local_flit,
    output logic              eject_valid,
    input  logic              eject_ready,
    output noc_pkg::sample_t  eject_sample,
    output logic              down_valid,
    input  logic              down_ready,
    output noc_pkg::flit_t    down_flit
);

    // End of the chain takes everything that arrives
    localparam bit IS_LAST = (NODE_ID == `NUM_NODES);

    logic           to_eject;
    logic           eject_in_valid;
    logic           eject_in_ready;
    logic           through_valid;
    logic           down_in_valid;
    logic           down_in_ready;
    noc_pkg::flit_t down_in_flit;

    assign to_eject = IS_LAST || (up_flit.addr == noc_pkg::node_id_t'(NODE_ID));

    assign eject_in_valid = up_valid && to_eject;
    assign through_valid  = up_valid && !to_eject;

    // Only the path this flit takes can stall upstream
    assign up_ready = to_eject ? eject_in_ready : down_in_ready;

    // Through traffic wins the downstream slot
    assign down_in_valid = through_valid || local_valid;
    assign down_in_flit  = through_valid ? up_flit : local_flit;
    assign local_ready   = down_in_ready && !through_valid;

    stream_slice #(
        .payload_t(noc_pkg::sample_t)
    ) u_eject_slice (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (eject_in_valid),
        .in_ready   (eject_in_ready),
        .in_payload (up_flit.payload),
        .out_valid  (eject_valid),
        .out_ready  (eject_ready),
        .out_payload(eject_sample)
    );

    stream_slice #(
        .payload_t(noc_pkg::flit_t)
    ) u_down_slice (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (down_in_valid),
        .in_ready   (down_in_ready),
        .in_payload (down_in_flit),
        .out_valid  (down_valid),
        .out_ready  (down_ready),
        .out_payload(down_flit)
    );

endmodule

// File: source/traffic_processor.sv
`timescale 1ns/100ps

module traffic_processor (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  noc_pkg::sample_t in_sample,
    output logic             sum_valid,
    input  logic             sum_ready,
    output noc_pkg::sum_t    sum
);

    noc_pkg::sum_t acc;
    logic          in_xfer;
    noc_pkg::sum_t sample_ext;

    // Hold off new samples while a sum is still waiting
    assign in_ready = !sum_valid;
    assign in_xfer  = in_valid && in_ready;

    // Zero extend up to accumulator width
    assign sample_ext = noc_pkg::sum_t'(in_sample);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc       <= '0;
            sum_valid <= 1'b0;
        end else begin
            if (in_xfer) begin
                acc       <= acc + sample_ext;
                sum_valid <= 1'b1;
            end else if (sum_ready) begin
                // Each new sum goes out exactly once
                sum_valid <= 1'b0;
            end
        end
    end

    assign sum = acc;

endmodule

// File: source/noc_node.sv
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_node #(
    parameter int NODE_ID = `FIRST_ROUTED_ID
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           up_valid,
    output logic           up_ready,
    input  noc_pkg::flit_t up_flit,
    output logic           down_valid,
    input  logic           down_ready,
    output noc_pkg::flit_t down_flit,
    output logic           sum_valid,
    input  logic           sum_ready,
    output noc_pkg::sum_t  sum
);

    logic             local_valid;
    logic             local_ready;
    noc_pkg::flit_t   local_flit;
    logic             eject_valid;
    logic             eject_ready;
    noc_pkg::sample_t eject_sample;
    logic             proc_sum_valid;
    logic             proc_sum_ready;
    noc_pkg::sum_t    proc_sum;

    node_router #(
        .NODE_ID(NODE_ID)
    ) u_router (
        .clk         (clk),
        .reset       (reset),
        .up_valid    (up_valid),
        .up_ready    (up_ready),
        .up_flit     (up_flit),
        .local_valid (local_valid),
        .local_ready (local_ready),
        .local_flit  (local_flit),
        .eject_valid (eject_valid),
        .eject_ready (eject_ready),
        .eject_sample(eject_sample),
        .down_valid  (down_valid),
        .down_ready  (down_ready),
        .down_flit   (down_flit)
    );

    traffic_processor u_proc (
        .clk      (clk),
        .reset    (reset),
        .in_valid (eject_valid),
        .in_ready (eject_ready),
        .in_sample(eject_sample),
        .sum_valid(proc_sum_valid),
        .sum_ready(proc_sum_ready),
        .sum      (proc_sum)
    );

    if (NODE_ID < `NUM_NODES) begin : g_inject
        noc_pkg::addr_sample_t inj_item;

        // Low half of the new sum goes to the next node
        assign inj_item.dest   = noc_pkg::node_id_t'(NODE_ID + 1);
        assign inj_item.sample = proc_sum[`NOC_DW-1:0];

        flit_packetizer u_pack (
            .in_valid  (proc_sum_valid),
            .in_ready  (proc_sum_ready),
            .in_item   (inj_item),
            .flit_valid(local_valid),
            .flit_ready(local_ready),
            .flit      (local_flit)
        );

        assign sum_valid = 1'b0;
        assign sum       = '0;
    end else begin : g_last
        // End node, sums leave the chain here
        assign local_valid    = 1'b0;
        assign local_flit     = '0;
        assign sum_valid      = proc_sum_valid;
        assign sum            = proc_sum;
        assign proc_sum_ready = sum_ready;
    end

endmodule

// File: source/noc_chain_top.sv
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_chain_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [`NOC_DW-1:0] in_data,
    input  logic [`ADDR_W-1:0] in_dest,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [`SUM_DW-1:0] out_sum
);

    noc_pkg::addr_sample_t ing_item;
    logic                  ing_valid;
    logic                  ing_ready;
    noc_pkg::addr_sample_t ing_slice_item;

    // Links are named by the node that drives them
    logic           link1_valid;
    logic           link1_ready;
    noc_pkg::flit_t link1_flit;
    logic           link2_valid;
    logic           link2_ready;
    noc_pkg::flit_t link2_flit;
    logic           link3_valid;
    logic           link3_ready;
    noc_pkg::flit_t link3_flit;

    assign ing_item.dest   = in_dest;
    assign ing_item.sample = in_data;

    // Node 1, registered ingress then flit packing
    stream_slice #(
        .payload_t(noc_pkg::addr_sample_t)
    ) u_ingress (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_payload (ing_item),
        .out_valid  (ing_valid),
        .out_ready  (ing_ready),
        .out_payload(ing_slice_item)
    );

    flit_packetizer u_node1_pack (
        .in_valid  (ing_valid),
        .in_ready  (ing_ready),
        .in_item   (ing_slice_item),
        .flit_valid(link1_valid),
        .flit_ready(link1_ready),
        .flit      (link1_flit)
    );

    noc_node #(.NODE_ID(`FIRST_ROUTED_ID)) u_node2 (
        .clk(clk), .reset(reset),
        .up_valid(link1_valid), .up_ready(link1_ready), .up_flit(link1_flit),
        .down_valid(link2_valid), .down_ready(link2_ready), .down_flit(link2_flit),
        .sum_valid(), .sum_ready(1'b0), .sum()
    );

    noc_node #(.NODE_ID(`FIRST_ROUTED_ID + 1)) u_node3 (
        .clk(clk), .reset(reset),
        .up_valid(link2_valid), .up_ready(link2_ready), .up_flit(link2_flit),
        .down_valid(link3_valid), .down_ready(link3_ready), .down_flit(link3_flit),
        .sum_valid(), .sum_ready(1'b0), .sum()
    );

    // Nothing sits past the end node
    noc_node #(.NODE_ID(`NUM_NODES)) u_node4 (
        .clk(clk), .reset(reset),
        .up_valid(link3_valid), .up_ready(link3_ready), .up_flit(link3_flit),
        .down_valid(), .down_ready(1'b0), .down_flit(),
        .sum_valid(out_valid), .sum_ready(out_ready), .sum(out_sum)
    );

endmodule

// File: dv/noc_chain_tb.sv
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_chain_tb;

    localparam int N_NODE4  = 16;
    localparam int N_NODE3  = 12;
    localparam int N_NODE2  = 12;
    localparam int N_STALL  = 24;
    localparam int N_SINGLE = 20;
    localparam int TOTAL_SAMPLES = N_NODE4 + N_NODE3 + N_NODE2 + N_STALL + N_SINGLE;
    // Ten cycles per sample plus reset and drain margin
    localparam int CYCLE_LIMIT = 10 * TOTAL_SAMPLES + 200;

    logic               clk = 1'b0;
    logic               reset;
    logic               in_valid;
    logic               in_ready;
    logic [`NOC_DW-1:0] in_data;
    logic [`ADDR_W-1:0] in_dest;
    logic               out_valid;
    logic               out_ready = 1'b1;
    logic [`SUM_DW-1:0] out_sum;

    integer seed;
    int     errors       = 0;
    int     sums_checked = 0;
    int     misc_checks  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     cycle_count  = 0;

    // Expected node 4 sums, in the order they must leave
    logic [`SUM_DW-1:0] exp_mem [0:TOTAL_SAMPLES-1];
    int                 exp_wr = 0;
    int                 exp_rd = 0;

    // Reference accumulators for nodes 2, 3 and 4
    logic [`SUM_DW-1:0] acc2 = '0;
    logic [`SUM_DW-1:0] acc3 = '0;
    logic [`SUM_DW-1:0] acc4 = '0;

    logic               sent_any     = 1'b0;
    logic               rand_ready   = 1'b0;
    logic               first_low    = 1'b1;
    int                 stretch_left = 0;
    logic               saw_in_stall = 1'b0;
    logic [`SUM_DW-1:0] prev_sum;
    logic [`NOC_DW-1:0] stall_data [0:N_STALL-1];

    noc_chain_top UUT (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_dest  (in_dest),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_sum  (out_sum)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        prev_sum <= out_sum;
        if (!reset && out_valid && out_ready) begin
            exp_rd       <= exp_rd + 1;
            sums_checked <= sums_checked + 1;
        end
        if (rand_ready && !in_ready && !out_ready) begin
            saw_in_stall <= 1'b1;
        end
    end

    // out_ready: held high, or alternating stretches
    always @(posedge clk) begin
        if (!rand_ready) begin
            out_ready    <= 1'b1;
            first_low    <= 1'b1;
            stretch_left <= 0;
        end else if (stretch_left == 0) begin
            out_ready <= !out_ready;
            // First low stretch is long enough to back up the whole chain
            stretch_left <= first_low ? 40 : 1 + ($unsigned($random(seed)) % 6);
            first_low    <= 1'b0;
        end else begin
            stretch_left <= stretch_left - 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // Each accepted sum matches the model, in order
    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && (exp_rd < exp_wr) |-> out_sum == exp_mem[exp_rd])
    else begin
        errors++;
        $display("CHECK FAILED at %0t: out_sum expected %h, got %h", $time,
                 exp_mem[$sampled(exp_rd)], $sampled(out_sum));
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready |-> exp_rd < exp_wr)
    else begin
        errors++;
        $display("Error at %0t: a sum came out that no sent sample accounts for", $time);
    end

    assert property (@(posedge clk) disable iff (reset) !sent_any |-> !out_valid)
    else begin
        errors++;
        $display("Error at %0t: out_valid rose before any sample was sent", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid)
    else begin
        errors++;
        $display("Error at %0t: out_valid dropped before its sum was taken", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_sum))
    else begin
        errors++;
        $display("CHECK FAILED at %0t: out_sum expected %h, got %h", $time,
                 $sampled(prev_sum), $sampled(out_sum));
    end

    // Chained accumulation, node 2 feeds 3 feeds 4
    task automatic model_sample(input logic [`ADDR_W-1:0] dest,
                                input logic [`NOC_DW-1:0] data);
        logic [`NOC_DW-1:0] word;
        word = data;
        if (dest == 2) begin
            acc2 = acc2 + `SUM_DW'(word);
            word = acc2[`NOC_DW-1:0];
        end
        if (dest == 2 || dest == 3) begin
            acc3 = acc3 + `SUM_DW'(word);
            word = acc3[`NOC_DW-1:0];
        end
        acc4 = acc4 + `SUM_DW'(word);
        exp_mem[exp_wr] = acc4;
        exp_wr++;
    endtask

    task automatic send_sample(input logic [`ADDR_W-1:0] dest,
                               input logic [`NOC_DW-1:0] data);
        in_valid <= 1'b1;
        in_data  <= data;
        in_dest  <= dest;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        sent_any = 1'b1;
        model_sample(dest, data);
    endtask

    // All expected sums seen and nothing left in flight
    task automatic wait_phase_done();
        @(posedge clk);
        while (exp_rd != exp_wr || out_valid || !in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic stream_phase(input logic [`ADDR_W-1:0] dest, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            send_sample(dest, $random(seed));
        end
        in_valid <= 1'b0;
        wait_phase_done();
    endtask

    task automatic report_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - err_mark);
        end
    endtask

    initial begin
        int err_mark;
        int wait_cycles;
        int i;
        logic [`ADDR_W-1:0] dest;
        seed     = 32'h01a9_7192;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        in_dest  = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        err_mark    = errors;
        wait_cycles = 0;
        while (!in_ready && wait_cycles < 10) begin
            @(posedge clk);
            wait_cycles++;
        end
        misc_checks++;
        assert (in_ready) else begin
            errors++;
            $display("Error at %0t: in_ready did not rise after reset", $time);
        end
        repeat (8) @(posedge clk);
        report_test("reset and idle", err_mark);

        err_mark = errors;
        stream_phase(4'd4, N_NODE4);
        report_test("node 4 stream", err_mark);

        err_mark = errors;
        stream_phase(4'd3, N_NODE3);
        report_test("node 3 chained", err_mark);

        err_mark = errors;
        stream_phase(4'd2, N_NODE2);
        report_test("node 2 chained", err_mark);

        // Data drawn up front so the ready process owns the generator
        err_mark = errors;
        for (i = 0; i < N_STALL; i++) begin
            stall_data[i] = $random(seed);
        end
        rand_ready <= 1'b1;
        for (i = 0; i < N_STALL; i++) begin
            send_sample(4'd2, stall_data[i]);
        end
        in_valid <= 1'b0;
        wait_phase_done();
        rand_ready <= 1'b0;
        @(posedge clk);
        misc_checks++;
        assert (saw_in_stall) else begin
            errors++;
            $display("Error at %0t: in_ready never fell while out_ready was low", $time);
        end
        report_test("back-pressure", err_mark);

        err_mark = errors;
        for (i = 0; i < N_SINGLE; i++) begin
            dest = 2 + ($unsigned($random(seed)) % 3);
            send_sample(dest, $random(seed));
            in_valid <= 1'b0;
            wait_phase_done();
        end
        report_test("single random destinations", err_mark);

        $display("%0d tests, %0d failed, %0d sums checked, %0d other checks, %0d errors",
                 tests_run, tests_failed, sums_checked, misc_checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/noc_pkg.sv
source/stream_slice.sv
source/flit_packetizer.sv
source/node_router.sv
source/traffic_processor.sv
source/noc_node.sv
source/noc_chain_top.sv
dv/noc_chain_tb.sv
